//--- project.f
rtl/bev_pkg.sv
rtl/bev_order_capture.sv
rtl/bev_ctrl.sv
rtl/bev_stock_calc.sv
rtl/bev_bridge_port.sv
rtl/bev_top.sv
bench/bev_bridge_model.sv
bench/tb_bev.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_bev -f project.f
	./obj_dir/Vtb_bev | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_bev.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bev
    import bev_pkg::*;
();

    localparam int num_cmds       = 400;
    localparam int cycles_per_cmd = 40;
    localparam int clk_period     = 100;

    logic        clk;
    logic        inf;
    logic        sel_action_valid;
    logic        type_valid;
    logic        size_valid;
    logic        date_valid;
    logic        box_no_valid;
    logic        box_sup_valid;
    action_t     act;
    bev_type_t   bev_type;
    bev_size_t   bev_size;
    date_t       date;
    logic [7:0]  box_no;
    ing_amt_t    ing;
    logic        out_valid;
    logic        complete;
    err_t        err_msg;
    bridge_req_t c_req;
    logic        c_out_valid;
    stock_rec_t  c_data_r;
    logic        load_en;
    logic [7:0]  load_addr;
    stock_rec_t  load_data;
    logic [7:0]  peek_addr;
    stock_rec_t  peek_data;

    // Expected contents of every box
    stock_rec_t  mirror [256];
    int          error_count;

    bev_top #(
        .box_addr_w (8)
    ) dut_i (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .act              (act),
        .bev_type         (bev_type),
        .bev_size         (bev_size),
        .date             (date),
        .box_no           (box_no),
        .ing              (ing),
        .out_valid        (out_valid),
        .complete         (complete),
        .err_msg          (err_msg),
        .c_req            (c_req),
        .c_out_valid      (c_out_valid),
        .c_data_r         (c_data_r)
    );

    bev_bridge_model bridge_model_i (
        .clk         (clk),
        .inf         (inf),
        .c_req       (c_req),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .peek_addr   (peek_addr),
        .peek_data   (peek_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic log_failure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic clear_strobes();
        sel_action_valid = 1'b0;
        type_valid       = 1'b0;
        size_valid       = 1'b0;
        date_valid       = 1'b0;
        box_no_valid     = 1'b0;
        box_sup_valid    = 1'b0;
    endtask

    // One edge where neither a result nor a bridge request may show up
    task automatic quiet_edge();
        @(posedge clk);
        if (out_valid)
            log_failure("out_valid outside a command's result");
        if (c_req.in_valid)
            log_failure("bridge request before the last input strobe");
        #10;
        clear_strobes();
    endtask

    // Mostly close to empty or close to full
    function automatic ing_amt_t random_amount();
        int pick;
        pick = $urandom_range(9, 0);
        if (pick < 4)
            return ing_amt_t'($urandom_range(1000, 0));
        else if (pick < 8)
            return ing_amt_t'($urandom_range(4095, 3000));
        return ing_amt_t'($urandom_range(4095, 0));
    endfunction

    function automatic stock_rec_t random_record();
        stock_rec_t rec;
        rec.black_tea       = random_amount();
        rec.green_tea       = random_amount();
        rec.milk            = random_amount();
        rec.pineapple_juice = random_amount();
        rec.month           = {4'd0, 4'($urandom_range(12, 1))};
        rec.day             = {3'd0, 5'($urandom_range(28, 1))};
        return rec;
    endfunction

    // Quarters of a cup drawn from black, green, milk, pineapple
    function automatic logic [15:0] recipe_quarters(bev_type_t t);
        case (t)
            black_tea:           return 16'h4000;
            milk_tea:            return 16'h3010;
            extra_milk_tea:      return 16'h2020;
            green_tea:           return 16'h0400;
            green_milk_tea:      return 16'h0220;
            pineapple_juice:     return 16'h0004;
            super_pineapple_tea: return 16'h2002;
            default:             return 16'h2011;
        endcase
    endfunction

    task automatic predict(
        input  action_t        a,
        input  bev_type_t      t,
        input  bev_size_t      sz,
        input  date_t          today,
        input  stock_rec_t     rec,
        input  ing_amt_t [3:0] amts,
        output err_t           e,
        output stock_rec_t     nrec
    );
        logic [15:0] q;
        int          unit;
        int          have [4];
        int          res [4];
        logic        expired;
        logic        short_any;
        logic        over_any;

        q       = recipe_quarters(t);
        unit    = (sz == s) ? size_s : (sz == m) ? size_m : size_l;
        have[0] = int'(rec.black_tea);
        have[1] = int'(rec.green_tea);
        have[2] = int'(rec.milk);
        have[3] = int'(rec.pineapple_juice);
        expired = (rec.month[3:0] < today.month) ||
                  (rec.month[3:0] == today.month && rec.day[4:0] < today.day);
        short_any = 1'b0;
        over_any  = 1'b0;
        e         = no_err;
        nrec      = rec;
        for (int i = 0; i < 4; i++)
        begin
            if (a == supply)
            begin
                res[i]   = have[i] + int'(amts[i]);
                over_any = over_any | (res[i] > ing_max);
                res[i]   = (res[i] > ing_max) ? ing_max : res[i];
            end
            else
            begin
                res[i]    = have[i] - unit * int'(q[(3 - i) * 4 +: 4]) / 4;
                short_any = short_any | (res[i] < 0);
            end
        end
        if (a == supply)
        begin
            e          = over_any ? ing_of : no_err;
            nrec.month = {4'd0, today.month};
            nrec.day   = {3'd0, today.day};
        end
        else if (expired)
            e = no_exp;
        else if (a == make_drink && short_any)
            e = no_ing;
        if (a == supply || (a == make_drink && e == no_err))
        begin
            nrec.black_tea       = ing_amt_t'(res[0]);
            nrec.green_tea       = ing_amt_t'(res[1]);
            nrec.milk            = ing_amt_t'(res[2]);
            nrec.pineapple_juice = ing_amt_t'(res[3]);
        end
    endtask

    task automatic load_memory();
        stock_rec_t rec;
        for (int addr = 0; addr < 256; addr++)
        begin
            rec          = random_record();
            mirror[addr] = rec;
            quiet_edge();
            load_en   = 1'b1;
            load_addr = 8'(addr);
            load_data = rec;
        end
        quiet_edge();
        load_en = 1'b0;
    endtask

    task automatic run_command(input int idx);
        action_t        a;
        bev_type_t      t;
        bev_size_t      sz;
        date_t          today;
        logic [7:0]     box;
        ing_amt_t [3:0] amts;
        err_t           exp_err;
        stock_rec_t     exp_rec;
        logic           exp_wr;
        int             errs_before;
        int             pick;
        int             waited;
        int             rd_seen;
        int             wr_seen;
        logic           got;
        logic           res_complete;
        err_t           res_err;

        errs_before = error_count;
        pick        = $urandom_range(3, 0);
        a           = (pick < 2) ? make_drink : (pick == 2) ? supply : check_date;
        t           = bev_type_t'($urandom_range(7, 0));
        sz          = bev_size_t'($urandom_range(2, 0));
        today.month = 4'($urandom_range(12, 1));
        today.day   = 5'($urandom_range(28, 1));
        box         = ($urandom_range(1, 0) == 1) ? 8'($urandom_range(7, 0)) :
                                                    8'($urandom_range(255, 0));
        for (int i = 0; i < 4; i++)
            amts[i] = random_amount();
        predict(a, t, sz, today, mirror[box], amts, exp_err, exp_rec);
        exp_wr = (a == supply) || (a == make_drink && exp_err == no_err);

        quiet_edge();
        sel_action_valid = 1'b1;
        act              = a;
        if (a == make_drink)
        begin
            quiet_edge();
            type_valid = 1'b1;
            bev_type   = t;
            quiet_edge();
            size_valid = 1'b1;
            bev_size   = sz;
        end
        // Stray box strobe in the date phase must be ignored
        if ($urandom_range(3, 0) == 0)
        begin
            quiet_edge();
            box_no_valid = 1'b1;
            box_no       = ~box;
        end
        quiet_edge();
        date_valid = 1'b1;
        date       = today;
        quiet_edge();
        box_no_valid = 1'b1;
        box_no       = box;
        if (a == supply)
        begin
            for (int i = 0; i < 4; i++)
            begin
                quiet_edge();
                box_sup_valid = 1'b1;
                ing           = amts[i];
            end
        end
        quiet_edge();

        waited       = 0;
        rd_seen      = 0;
        wr_seen      = 0;
        got          = 1'b0;
        res_complete = 1'b0;
        res_err      = no_err;
        while (!got && waited < cycles_per_cmd)
        begin
            @(posedge clk);
            waited++;
            if (c_req.in_valid)
            begin
                if (c_req.r_wb)
                    rd_seen++;
                else
                    wr_seen++;
                if (c_req.addr !== box)
                    log_failure($sformatf("bridge address %0d, expected %0d", c_req.addr, box));
            end
            if (out_valid)
            begin
                got          = 1'b1;
                res_complete = complete;
                res_err      = err_msg;
            end
        end

        if (!got)
            log_failure($sformatf("no out_valid within %0d cycles", cycles_per_cmd));
        if (got && res_err !== exp_err)
            log_failure($sformatf("err_msg %s, expected %s", res_err.name(), exp_err.name()));
        if (got && res_complete !== (exp_err == no_err))
            log_failure($sformatf("complete %0b for %s", res_complete, exp_err.name()));
        if (rd_seen != 1)
            log_failure($sformatf("%0d read requests, expected 1", rd_seen));
        if (wr_seen != (exp_wr ? 1 : 0))
            log_failure($sformatf("%0d write requests, expected %0d", wr_seen, exp_wr));
        if (exp_wr)
            mirror[box] = exp_rec;
        peek_addr = box;
        #1;
        if (peek_data !== mirror[box])
            log_failure($sformatf("box %0d holds %h, expected %h", box, peek_data, mirror[box]));
        $display("cmd %0d %s box %0d: %s, %s", idx, a.name(), box, exp_err.name(),
                 (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    initial
    begin
        #(num_cmds * cycles_per_cmd * clk_period);
        $display("Timeout: the run did not finish within %0d commands' time", num_cmds);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h4690_5622));
        clear_strobes();
        act         = make_drink;
        bev_type    = black_tea;
        bev_size    = s;
        date        = '0;
        box_no      = '0;
        ing         = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        peek_addr   = '0;
        error_count = 0;
        inf         = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        inf = 1'b1;

        load_memory();
        for (int i = 0; i < num_cmds; i++)
        begin
            repeat ($urandom_range(2, 0)) quiet_edge();
            run_command(i);
        end
        quiet_edge();

        $display("Summary: %0d commands run, %0d errors", num_cmds, error_count);
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/bev_bridge_model.sv
`timescale 1ns/10ps
`default_nettype none

module bev_bridge_model
    import bev_pkg::*;
(
    input  logic        clk,
    input  logic        inf,
    input  bridge_req_t c_req,
    output logic        c_out_valid,
    output stock_rec_t  c_data_r,
    input  logic        load_en,
    input  logic [7:0]  load_addr,
    input  stock_rec_t  load_data,
    input  logic [7:0]  peek_addr,
    output stock_rec_t  peek_data
);

    stock_rec_t  mem [256];
    bridge_req_t req_q;
    logic        busy;
    int unsigned wait_cnt;
    logic        respond;

    assign respond   = busy && (wait_cnt == 0);
    assign peek_data = mem[peek_addr];

    // Answer 1 to 8 cycles after the request
    always @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            busy        <= 1'b0;
            wait_cnt    <= 0;
            c_out_valid <= 1'b0;
        end
        else
        begin
            c_out_valid <= respond;
            if (c_req.in_valid)
            begin
                busy     <= 1'b1;
                req_q    <= c_req;
                wait_cnt <= $urandom_range(7, 0);
            end
            else if (respond)
            begin
                busy <= 1'b0;
            end
            else if (busy)
            begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    always @(posedge clk)
    begin
        if (load_en)
            mem[load_addr] <= load_data;
        else if (respond && !req_q.r_wb)
            mem[req_q.addr] <= req_q.data_w;
        if (respond)
            c_data_r <= mem[req_q.addr];
    end

endmodule

`default_nettype wire

//--- rtl/bev_top.sv
`timescale 1ns/10ps
`default_nettype none

module bev_top
    import bev_pkg::*;
#(
    parameter int box_addr_w = 8
)
(
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  sel_action_valid,
    input  logic                  type_valid,
    input  logic                  size_valid,
    input  logic                  date_valid,
    input  logic                  box_no_valid,
    input  logic                  box_sup_valid,
    input  action_t               act,
    input  bev_type_t             bev_type,
    input  bev_size_t             bev_size,
    input  date_t                 date,
    input  logic [box_addr_w-1:0] box_no,
    input  ing_amt_t              ing,
    output logic                  out_valid,
    output logic                  complete,
    output err_t                  err_msg,
    output bridge_req_t           c_req,
    input  logic                  c_out_valid,
    input  stock_rec_t            c_data_r
);

    order_t         order;
    ing_amt_t [3:0] sup_amts;
    logic           sup_count_done;
    ctrl_state_t    phase;
    logic           req_rd;
    logic           req_wr;
    logic           load_calc;
    logic           rd_done;
    logic           wr_done;
    stock_rec_t     stock;
    stock_rec_t     new_stock;
    err_t           calc_err;
    logic           calc_complete;

    bev_order_capture capture_i (
        .clk              (clk),
        .inf              (inf),
        .phase            (phase),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .box_sup_valid    (box_sup_valid),
        .act              (act),
        .bev_type         (bev_type),
        .bev_size         (bev_size),
        .date             (date),
        .box_no           (box_no),
        .ing              (ing),
        .order            (order),
        .sup_amts         (sup_amts),
        .sup_count_done   (sup_count_done)
    );

    bev_ctrl ctrl_i (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .sup_count_done   (sup_count_done),
        .order            (order),
        .rd_done          (rd_done),
        .wr_done          (wr_done),
        .err              (calc_err),
        .complete_in      (calc_complete),
        .phase            (phase),
        .req_rd           (req_rd),
        .req_wr           (req_wr),
        .load_calc        (load_calc),
        .out_valid        (out_valid),
        .complete         (complete),
        .err_msg          (err_msg)
    );

    bev_stock_calc calc_i (
        .order     (order),
        .sup_amts  (sup_amts),
        .stock     (stock),
        .new_stock (new_stock),
        .err       (calc_err),
        .complete  (calc_complete)
    );

    bev_bridge_port #(
        .box_addr_w (box_addr_w)
    ) bridge_i (
        .clk         (clk),
        .inf         (inf),
        .order       (order),
        .req_rd      (req_rd),
        .req_wr      (req_wr),
        .load_calc   (load_calc),
        .new_stock   (new_stock),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r),
        .c_req       (c_req),
        .stock       (stock),
        .rd_done     (rd_done),
        .wr_done     (wr_done)
    );

endmodule

`default_nettype wire

//--- rtl/bev_bridge_port.sv
`timescale 1ns/10ps
`default_nettype none

module bev_bridge_port
    import bev_pkg::*;
#(
    parameter int box_addr_w = 8
)
(
    input  logic        clk,
    input  logic        inf,
    input  order_t      order,
    input  logic        req_rd,
    input  logic        req_wr,
    input  logic        load_calc,
    input  stock_rec_t  new_stock,
    input  logic        c_out_valid,
    input  stock_rec_t  c_data_r,
    output bridge_req_t c_req,
    output stock_rec_t  stock,
    output logic        rd_done,
    output logic        wr_done
);

    logic                  in_valid_q;
    logic                  pending_q;
    logic                  r_wb_q;
    logic [box_addr_w-1:0] addr_q;

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            in_valid_q <= 1'b0;
            pending_q  <= 1'b0;
        end
        else
        begin
            in_valid_q <= req_rd || req_wr;
            if (c_out_valid)
                pending_q <= 1'b0;
            else if (in_valid_q)
                pending_q <= 1'b1;
        end
    end

    // Held until the response, nothing else loads them meanwhile
    always_ff @(posedge clk)
    begin
        if (req_rd || req_wr)
        begin
            r_wb_q <= req_rd;
            addr_q <= order.box_no;
        end
    end

    assign rd_done = c_out_valid && r_wb_q;
    assign wr_done = c_out_valid && !r_wb_q;

    // Working record, replaced by the result at evaluate
    always_ff @(posedge clk)
    begin
        if (rd_done)
            stock <= c_data_r;
        else if (load_calc)
            stock <= new_stock;
    end

    assign c_req = '{in_valid: in_valid_q, r_wb: r_wb_q, addr: addr_q, data_w: stock};

    a_no_overlap : assert property (@(posedge clk) disable iff (!inf)
        c_req.in_valid |-> !pending_q)
        else $error("bridge request issued with a response outstanding");

endmodule

`default_nettype wire

//--- rtl/bev_stock_calc.sv
`timescale 1ns/10ps
`default_nettype none

module bev_stock_calc
    import bev_pkg::*;
(
    input  order_t         order,
    input  ing_amt_t [3:0] sup_amts,
    input  stock_rec_t     stock,
    output stock_rec_t     new_stock,
    output err_t           err,
    output logic           complete
);

    ing_amt_t         unit;
    ing_amt_t         half;
    ing_amt_t         quarter;
    ing_amt_t [3:0]   cur;
    ing_amt_t [3:0]   need;
    ing_amt_t [3:0]   sat;
    logic [3:0][12:0] left;
    logic [3:0][12:0] sum;
    logic             expired;
    logic             short;
    logic             over;

    // Index 0 black, 1 green, 2 milk, 3 pineapple
    assign cur = {stock.pineapple_juice, stock.milk, stock.green_tea, stock.black_tea};

    assign expired = (stock.month[3:0] < order.date.month) ||
                     (stock.month[3:0] == order.date.month && stock.day[4:0] < order.date.day);

    always_comb
    begin
        case (order.bev_size)
            s:       unit = ing_amt_t'(size_s);
            m:       unit = ing_amt_t'(size_m);
            default: unit = ing_amt_t'(size_l);
        endcase
    end

    assign half    = unit >> 1;
    assign quarter = unit >> 2;

    // Recipe shares of one cup
    always_comb
    begin
        need = '0;
        case (order.bev_type)
            black_tea:       need[0] = unit;
            milk_tea:
            begin
                need[0] = unit - quarter;
                need[2] = quarter;
            end
            extra_milk_tea:
            begin
                need[0] = half;
                need[2] = half;
            end
            green_tea:       need[1] = unit;
            green_milk_tea:
            begin
                need[1] = half;
                need[2] = half;
            end
            pineapple_juice: need[3] = unit;
            super_pineapple_tea:
            begin
                need[0] = half;
                need[3] = half;
            end
            default:
            begin
                need[0] = half;
                need[2] = quarter;
                need[3] = quarter;
            end
        endcase
    end

    // Bit 12 flags borrow on a draw and carry on a restock
    always_comb
    begin
        short = 1'b0;
        over  = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            left[i] = {1'b0, cur[i]} - {1'b0, need[i]};
            sum[i]  = {1'b0, cur[i]} + {1'b0, sup_amts[i]};
            sat[i]  = sum[i][12] ? ing_amt_t'(ing_max) : sum[i][11:0];
            short   = short | left[i][12];
            over    = over | sum[i][12];
        end
    end

    always_comb
    begin
        new_stock = stock;
        err       = no_err;
        case (order.act)
            make_drink:
            begin
                if (expired)
                begin
                    err = no_exp;
                end
                else if (short)
                begin
                    err = no_ing;
                end
                else
                begin
                    new_stock.black_tea       = left[0][11:0];
                    new_stock.green_tea       = left[1][11:0];
                    new_stock.milk            = left[2][11:0];
                    new_stock.pineapple_juice = left[3][11:0];
                end
            end
            supply:
            begin
                if (over)
                begin
                    err = ing_of;
                end
                new_stock.black_tea       = sat[0];
                new_stock.green_tea       = sat[1];
                new_stock.milk            = sat[2];
                new_stock.pineapple_juice = sat[3];
                new_stock.month           = {4'd0, order.date.month};
                new_stock.day             = {3'd0, order.date.day};
            end
            default:
            begin
                if (expired)
                begin
                    err = no_exp;
                end
            end
        endcase
    end

    assign complete = (err == no_err);

endmodule

`default_nettype wire

//--- rtl/bev_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module bev_ctrl
    import bev_pkg::*;
(
    input  logic        clk,
    input  logic        inf,
    input  logic        sel_action_valid,
    input  logic        type_valid,
    input  logic        size_valid,
    input  logic        date_valid,
    input  logic        box_no_valid,
    input  logic        sup_count_done,
    input  order_t      order,
    input  logic        rd_done,
    input  logic        wr_done,
    input  err_t        err,
    input  logic        complete_in,
    output ctrl_state_t phase,
    output logic        req_rd,
    output logic        req_wr,
    output logic        load_calc,
    output logic        out_valid,
    output logic        complete,
    output err_t        err_msg
);

    ctrl_state_t state_q;
    ctrl_state_t state_n;
    logic        need_wr;

    // The action is only known one cycle after its strobe, so the state
    // after idle is get_type and the phase is decoded from the action
    always_comb
    begin
        phase = state_q;
        if (state_q == get_type && order.act != make_drink)
        begin
            phase = (order.act == supply || order.act == check_date) ? get_date : idle;
        end
    end

    // Supply always stores its saturated record
    assign need_wr   = (order.act == supply) || (order.act == make_drink && err == no_err);
    assign load_calc = (phase == evaluate);

    always_comb
    begin
        state_n = phase;
        case (phase)
            idle:       if (sel_action_valid) state_n = get_type;
            get_type:   if (type_valid) state_n = get_size;
            get_size:   if (size_valid) state_n = get_date;
            get_date:   if (date_valid) state_n = get_box;
            get_box:
            begin
                if (box_no_valid)
                begin
                    state_n = (order.act == supply) ? get_supply : read;
                end
            end
            get_supply: if (sup_count_done) state_n = read;
            read:       if (rd_done) state_n = evaluate;
            evaluate:   state_n = need_wr ? write : report;
            write:      if (wr_done) state_n = report;
            default:    state_n = idle;
        endcase
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            state_q   <= idle;
            req_rd    <= 1'b0;
            req_wr    <= 1'b0;
            out_valid <= 1'b0;
            complete  <= 1'b0;
            err_msg   <= no_err;
        end
        else
        begin
            state_q   <= state_n;
            req_rd    <= (state_n == read) && (phase != read);
            req_wr    <= (phase == evaluate) && need_wr;
            out_valid <= (state_n == report);
            if (phase == evaluate)
            begin
                err_msg  <= err;
                complete <= complete_in;
            end
            else if (phase == report)
            begin
                err_msg  <= no_err;
                complete <= 1'b0;
            end
        end
    end

    // Bridge responses only while one is awaited
    a_rd_done_in_read : assert property (@(posedge clk) disable iff (!inf)
        rd_done |-> phase == read)
        else $error("read response outside the read phase");

    a_wr_done_in_write : assert property (@(posedge clk) disable iff (!inf)
        wr_done |-> phase == write)
        else $error("write response outside the write phase");

endmodule

`default_nettype wire

//--- rtl/bev_order_capture.sv
`timescale 1ns/10ps
`default_nettype none

module bev_order_capture
    import bev_pkg::*;
(
    input  logic                      clk,
    input  logic                      inf,
    input  ctrl_state_t               phase,
    input  logic                      sel_action_valid,
    input  logic                      type_valid,
    input  logic                      size_valid,
    input  logic                      date_valid,
    input  logic                      box_no_valid,
    input  logic                      box_sup_valid,
    input  action_t                   act,
    input  bev_type_t                 bev_type,
    input  bev_size_t                 bev_size,
    input  date_t                     date,
    input  logic [box_addr_w_def-1:0] box_no,
    input  ing_amt_t                  ing,
    output order_t                    order,
    output ing_amt_t [3:0]            sup_amts,
    output logic                      sup_count_done
);

    logic [1:0] sup_cnt;
    logic       sup_take;

    assign sup_take       = (phase == get_supply) && box_sup_valid;
    assign sup_count_done = sup_take && (sup_cnt == 2'd3);

    // Each field is taken only in its own phase
    always_ff @(posedge clk)
    begin
        if (sel_action_valid && phase == idle)
        begin
            order.act <= act;
        end
        if (type_valid && phase == get_type)
        begin
            order.bev_type <= bev_type;
        end
        if (size_valid && phase == get_size)
        begin
            order.bev_size <= bev_size;
        end
        if (date_valid && phase == get_date)
        begin
            order.date <= date;
        end
        if (box_no_valid && phase == get_box)
        begin
            order.box_no <= box_no;
        end
    end

    // Amounts arrive black, green, milk, pineapple
    always_ff @(posedge clk)
    begin
        if (sup_take)
        begin
            sup_amts[sup_cnt] <= ing;
        end
    end

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            sup_cnt <= 2'd0;
        end
        else if (phase == idle)
        begin
            sup_cnt <= 2'd0;
        end
        else if (sup_take)
        begin
            sup_cnt <= sup_cnt + 2'd1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bev_pkg.sv
`default_nettype none

package bev_pkg;

    // Width of the box number, also the bridge address
    localparam int box_addr_w_def = 8;

    // Recipe sizes and ingredient ceiling
    localparam int size_s  = 480;
    localparam int size_m  = 720;
    localparam int size_l  = 960;
    localparam int ing_max = 4095;

    typedef logic [11:0] ing_amt_t;

    typedef enum logic [1:0]
    {
        make_drink = 2'd0,
        supply     = 2'd1,
        check_date = 2'd2
    } action_t;

    typedef enum logic [2:0]
    {
        black_tea                = 3'd0,
        milk_tea                 = 3'd1,
        extra_milk_tea           = 3'd2,
        green_tea                = 3'd3,
        green_milk_tea           = 3'd4,
        pineapple_juice          = 3'd5,
        super_pineapple_tea      = 3'd6,
        super_pineapple_milk_tea = 3'd7
    } bev_type_t;

    typedef enum logic [1:0]
    {
        s = 2'd0,
        m = 2'd1,
        l = 2'd2
    } bev_size_t;

    typedef enum logic [1:0]
    {
        no_err = 2'd0,
        no_exp = 2'd1,
        no_ing = 2'd2,
        ing_of = 2'd3
    } err_t;

    // Command sequencer phases, also seen by the input capture
    typedef enum logic [3:0]
    {
        idle,
        get_type,
        get_size,
        get_date,
        get_box,
        get_supply,
        read,
        evaluate,
        write,
        report
    } ctrl_state_t;

    typedef struct packed
    {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    // Memory layout of one box, 64 bits
    typedef struct packed
    {
        ing_amt_t   black_tea;
        ing_amt_t   green_tea;
        logic [7:0] month;
        ing_amt_t   milk;
        ing_amt_t   pineapple_juice;
        logic [7:0] day;
    } stock_rec_t;

    typedef struct packed
    {
        logic                      in_valid;
        logic                      r_wb;
        logic [box_addr_w_def-1:0] addr;
        stock_rec_t                data_w;
    } bridge_req_t;

    typedef struct packed
    {
        action_t                   act;
        bev_type_t                 bev_type;
        bev_size_t                 bev_size;
        date_t                     date;
        logic [box_addr_w_def-1:0] box_no;
    } order_t;

endpackage

`default_nettype wire
